//--- Makefile
.PHONY: all build lint clean

all: build
	@out="$$(./obj_dir/Vtb_radar_digitizer)"; echo "$$out"; \
	echo "$$out" | grep -q "SIMULATION PASSED"

build:
	verilator --binary --timing --assert -j 0 -f filelist.f \
		--top-module tb_radar_digitizer -Mdir obj_dir

lint:
	verilator --lint-only --timing -f filelist.f --top-module tb_radar_digitizer

clean:
	rm -rf obj_dir

//--- filelist.f
radar_pkg.sv
pulse_detector.sv
sweep_tracker.sv
pulse_sequencer.sv
sample_select.sv
radar_digitizer.sv
radar_digitizer_chk.sv
tb_radar_digitizer.sv

//--- pulse_detector.sv
// threshold pulse detector with excite/relax hysteresis
// one-cycle strobe, pulse count, last interval and age
`timescale 1ns/100ps

module pulse_detector import radar_pkg::*;
(
   input  logic             clk64,
   input  logic             rx_dsp_reset,
   input  logic             enable,         // inputs ignored while low
   input  logic [adc_w-1:0] signal,
   input  logic [adc_w-1:0] thresh_excite,  // fire at or above this
   input  logic [adc_w-1:0] thresh_relax,   // re-arm at or below this
   output logic             strobe,         // one cycle per detected pulse
   output logic [cnt_w-1:0] count,          // pulses since reset
   output logic [cnt_w-1:0] interval,       // cycles between the last two pulses
   output logic [cnt_w-1:0] age             // cycles since the last pulse
);

   logic armed;  // waiting for the next excite crossing
   logic above;  // signal at or above excite
   logic below;  // signal at or below relax
   logic fire;   // crossing seen this edge

   assign above = (signal >= thresh_excite);
   assign below = (signal <= thresh_relax);
   assign fire  = enable & armed & above;  // comparison result lands in strobe next cycle

   // hysteresis and strobe
   always_ff @(posedge clk64)
   begin
      if (rx_dsp_reset)
      begin
         armed  <= 1'b1;  // start armed
         strobe <= 1'b0;
      end
      else
      begin
         strobe <= fire;
         if (fire)
            armed <= 1'b0;  // hold off until the signal relaxes
         else if (enable & below)
            armed <= 1'b1;
      end
   end

   // pulse bookkeeping, updated together with the strobe
   always_ff @(posedge clk64)
   begin
      if (rx_dsp_reset)
      begin
         count    <= '0;
         interval <= '0;
         age      <= '0;
      end
      else if (fire)
      begin
         count    <= count + 1'b1;
         interval <= age + 1'b1;  // age still counts from the previous strobe
         age      <= '0;          // restart on the strobe cycle
      end
      else
      begin
         age <= age + 1'b1;
      end
   end

endmodule

//--- pulse_sequencer.sv
// receive settling delay, capture start, clock decimation,
// sample count per capture and interleave phase
`timescale 1ns/100ps

module pulse_sequencer import radar_pkg::*;
#(
   parameter int ENABLE_DELAY = 12800000,  // settling cycles after enable
   parameter int DECIM_W      = 16
)
(
   input  logic               clk64,
   input  logic               rx_dsp_reset,
   input  logic               eventually_enable_rx,
   input  logic               trigger_strobe,
   input  logic               new_mode,         // latch non-stop from radar_mode
   input  logic [mode_w-1:0]  radar_mode,
   input  logic [DECIM_W-1:0] decim_rate,
   input  logic [cnt_w-1:0]   n_samples,        // samples per capture
   output logic               enable_rx,
   output logic               start_pipeline,   // one cycle at capture start
   output logic               pipeline_active,
   output logic               decim_strobe,     // one cycle per sample
   output logic [1:0]         phase             // interleave slot
);

   localparam int settle_w = (ENABLE_DELAY > 0) ? $clog2(ENABLE_DELAY + 1) : 1;

   logic                non_stop;    // capture back to back
   logic                start;
   logic                last_tick;   // decimation period complete
   logic [settle_w-1:0] settle_cnt;
   logic [DECIM_W-1:0]  decim_cnt;
   logic [cnt_w-1:0]    remaining;   // samples left in this capture

   assign start     = enable_rx & ~pipeline_active & (trigger_strobe | non_stop);
   assign last_tick = (decim_cnt == decim_rate - 1'b1) | (decim_rate == '0);

   always_ff @(posedge clk64)
   begin
      if (rx_dsp_reset)
      begin
         non_stop        <= 1'b0;
         enable_rx       <= 1'b0;
         settle_cnt      <= settle_w'(ENABLE_DELAY);
         start_pipeline  <= 1'b0;
         pipeline_active <= 1'b0;
         decim_strobe    <= 1'b0;
         decim_cnt       <= '0;
         remaining       <= '0;
         phase           <= 2'd0;
      end
      else
      begin
         if (new_mode)
            non_stop <= |radar_mode;  // any mode but video runs non-stop
         if (eventually_enable_rx)
         begin
            if (settle_cnt != '0)
               settle_cnt <= settle_cnt - 1'b1;
            else
               enable_rx <= 1'b1;
         end
         else
         begin
            enable_rx  <= 1'b0;  // drop at once, settle again next time
            settle_cnt <= settle_w'(ENABLE_DELAY);
         end
         start_pipeline <= start;
         decim_strobe   <= 1'b0;
         if (start)
         begin
            pipeline_active <= 1'b1;
            decim_cnt       <= '0;
            remaining       <= n_samples;
         end
         else if (pipeline_active)
         begin
            if (!enable_rx)
               pipeline_active <= 1'b0;  // abort the capture
            else if (last_tick)
            begin
               decim_cnt    <= '0;
               decim_strobe <= 1'b1;
               remaining    <= remaining - 1'b1;
               if (remaining < cnt_w'(2))
                  pipeline_active <= 1'b0;  // falls with the last strobe
            end
            else
               decim_cnt <= decim_cnt + 1'b1;
         end
         if (start)
            phase <= 2'd0;  // every capture begins with video
         else if (decim_strobe)
            phase <= phase + 2'd1;
      end
   end

endmodule

//--- radar_digitizer.sv
// radar pulse digitizer top level
// source selector, three pulse detectors, sweep tracker and sequencer
`timescale 1ns/100ps

module radar_digitizer import radar_pkg::*;
#(
   parameter int ENABLE_DELAY = 12800000,
   parameter int DECIM_W      = 16
)
(
   input  logic                clk64,
   input  logic                rx_dsp_reset,
   input  logic                eventually_enable_rx,
   input  logic [adc_w-1:0]    rx_a_a,
   input  logic [adc_w-1:0]    rx_b_a,
   input  logic [adc_w-1:0]    rx_a_b,
   input  logic [adc_w-1:0]    rx_b_b,
   input  logic [3:0]          io_bits,
   input  logic [src_w-1:0]    vid_source,
   input  logic [src_w-1:0]    trg_source,
   input  logic [src_w-1:0]    arp_source,
   input  logic [src_w-1:0]    acp_source,
   input  logic [mode_w-1:0]   radar_mode,
   input  logic                new_mode,
   input  logic                vid_negate,
   input  logic [DECIM_W-1:0]  decim_rate,
   input  logic [cnt_w-1:0]    n_samples,
   input  logic [adc_w-1:0]    trig_thresh_excite,
   input  logic [adc_w-1:0]    trig_thresh_relax,
   input  logic [adc_w-1:0]    arp_thresh_excite,
   input  logic [adc_w-1:0]    arp_thresh_relax,
   input  logic [adc_w-1:0]    acp_thresh_excite,
   input  logic [adc_w-1:0]    acp_thresh_relax,
   input  logic                use_acp_for_sweeps,
   input  logic [15:0]         n_acps_per_sweep,
   output logic                sample_valid,
   output logic [sample_w-1:0] sample_data,
   output logic                enable_rx,
   output logic                pipeline_active,
   output logic [cnt_w-1:0]    n_trigs,
   output logic [cnt_w-1:0]    n_arps,
   output logic [cnt_w-1:0]    n_acps,
   output logic [cnt_w-1:0]    trig_interval,
   output logic [cnt_w-1:0]    acp_count_last_arp,
   output logic [cnt_w-1:0]    acp_age_last_arp,
   output logic [cnt_w-1:0]    last_acp_interval_with_trig,
   output logic [cnt_w-1:0]    last_acp_interval_with_arp,
   output logic [15:0]         acps_this_sweep,
   output logic [cnt_w-1:0]    ticks_this_sweep
);

   logic [adc_w-1:0] vid_signal, trg_signal, arp_signal, acp_signal;  // routed signals
   logic             trigger_strobe, arp_strobe, acp_strobe;
   logic [cnt_w-1:0] acp_interval, acp_age;
   logic             start_pipeline, decim_strobe;
   logic [1:0]       phase;  // interleave slot

   sample_select sel (
      .clk64, .rx_dsp_reset, .rx_a_a, .rx_b_a, .rx_a_b, .rx_b_b, .io_bits,
      .vid_source, .trg_source, .arp_source, .acp_source, .radar_mode, .vid_negate,
      .decim_strobe, .phase, .vid_signal, .trg_signal, .arp_signal, .acp_signal,
      .sample_valid, .sample_data);

   pulse_detector trig_det (
      .clk64, .rx_dsp_reset, .enable(enable_rx), .signal(trg_signal),
      .thresh_excite(trig_thresh_excite), .thresh_relax(trig_thresh_relax),
      .strobe(trigger_strobe), .count(n_trigs), .interval(trig_interval), .age());

   pulse_detector arp_det (  // heading marker
      .clk64, .rx_dsp_reset, .enable(enable_rx), .signal(arp_signal),
      .thresh_excite(arp_thresh_excite), .thresh_relax(arp_thresh_relax),
      .strobe(arp_strobe), .count(n_arps), .interval(), .age());

   pulse_detector acp_det (  // azimuth counts
      .clk64, .rx_dsp_reset, .enable(enable_rx), .signal(acp_signal),
      .thresh_excite(acp_thresh_excite), .thresh_relax(acp_thresh_relax),
      .strobe(acp_strobe), .count(n_acps), .interval(acp_interval), .age(acp_age));

   sweep_tracker trk (
      .clk64, .rx_dsp_reset, .trig_strobe(trigger_strobe), .arp_strobe, .acp_strobe,
      .sweep_start(start_pipeline), .n_acps, .acp_interval, .acp_age,
      .use_acp_for_sweeps, .n_acps_per_sweep, .acp_count_last_arp, .acp_age_last_arp,
      .last_acp_interval_with_trig, .last_acp_interval_with_arp,
      .acps_this_sweep, .ticks_this_sweep);

   pulse_sequencer #(
      .ENABLE_DELAY(ENABLE_DELAY),
      .DECIM_W     (DECIM_W)
   ) seq (
      .clk64, .rx_dsp_reset, .eventually_enable_rx, .trigger_strobe, .new_mode,
      .radar_mode, .decim_rate, .n_samples, .enable_rx, .start_pipeline,
      .pipeline_active, .decim_strobe, .phase);

endmodule

//--- radar_digitizer_chk.sv
// protocol assertions bound into the digitizer top level
`timescale 1ns/100ps

module radar_digitizer_chk
(
   input logic clk64,
   input logic rx_dsp_reset,
   input logic eventually_enable_rx,
   input logic enable_rx,
   input logic trigger_strobe,
   input logic arp_strobe,
   input logic acp_strobe,
   input logic start_pipeline,
   input logic pipeline_active,
   input logic sample_valid
);

   // strobes last one cycle
   a_trig_one: assert property (@(posedge clk64) disable iff (rx_dsp_reset)
      trigger_strobe |=> !trigger_strobe) else $error("trigger strobe too wide");
   a_arp_one: assert property (@(posedge clk64) disable iff (rx_dsp_reset)
      arp_strobe |=> !arp_strobe) else $error("arp strobe too wide");
   a_acp_one: assert property (@(posedge clk64) disable iff (rx_dsp_reset)
      acp_strobe |=> !acp_strobe) else $error("acp strobe too wide");
   a_start_one: assert property (@(posedge clk64) disable iff (rx_dsp_reset)
      start_pipeline |=> !start_pipeline) else $error("start_pipeline too wide");

   // last strobe shares the cycle where active falls, its sample lands one cycle later
   a_valid_in_capture: assert property (@(posedge clk64) disable iff (rx_dsp_reset)
      sample_valid |-> (pipeline_active || $past(pipeline_active, 2)))
      else $error("sample_valid outside a capture");

   a_enable_follows: assert property (@(posedge clk64) disable iff (rx_dsp_reset)
      !$past(eventually_enable_rx) |-> !enable_rx) else $error("enable_rx without request");

endmodule

bind radar_digitizer radar_digitizer_chk chk (
   .clk64, .rx_dsp_reset, .eventually_enable_rx, .enable_rx, .trigger_strobe,
   .arp_strobe, .acp_strobe, .start_pipeline, .pipeline_active, .sample_valid);

//--- radar_pkg.sv
// widths, source codes and mode codes for the radar digitizer
// plus the full-scale reference used to negate video
package radar_pkg;

   // widths
   localparam int adc_w    = 12;  // one radar sample from a channel
   localparam int sample_w = 16;  // output stream word, top 4 bits zero
   localparam int cnt_w    = 32;  // counts, intervals and ages
   localparam int src_w    = 8;   // signal source selector
   localparam int mode_w   = 3;   // radar mode selector

   // signal sources, 12-bit channels
   localparam logic [src_w-1:0] src_rx_a_a = 8'd0;
   localparam logic [src_w-1:0] src_rx_b_a = 8'd1;
   localparam logic [src_w-1:0] src_rx_a_b = 8'd2;
   localparam logic [src_w-1:0] src_rx_b_b = 8'd3;

   // signal sources, single digital pins of io_bits
   // the pin lands in the sample msb, all other bits zero
   localparam logic [src_w-1:0] src_io_a0  = 8'd4;  // io_bits[0]
   localparam logic [src_w-1:0] src_io_a1  = 8'd5;  // io_bits[1]
   localparam logic [src_w-1:0] src_io_b0  = 8'd6;  // io_bits[2]
   localparam logic [src_w-1:0] src_io_b1  = 8'd7;  // io_bits[3]
   // any other code routes a zero signal

   // radar modes
   localparam logic [mode_w-1:0] mode_video      = 3'd0;  // pulse synced video
   localparam logic [mode_w-1:0] mode_raw_vid    = 3'd1;
   localparam logic [mode_w-1:0] mode_raw_trg    = 3'd2;
   localparam logic [mode_w-1:0] mode_raw_arp    = 3'd3;
   localparam logic [mode_w-1:0] mode_raw_acp    = 3'd4;
   localparam logic [mode_w-1:0] mode_interleave = 3'd5;  // vid, trg, arp, acp in turn
   // codes 6 and 7 give zero samples

   // full scale of a channel, negated video is adc_full - video
   localparam logic [adc_w-1:0] adc_full = 12'd4095;

endpackage

//--- sample_select.sv
// routing of channels and pins to the four radar signals
// and the registered sample multiplexer for each radar mode
`timescale 1ns/100ps

module sample_select import radar_pkg::*;
(
   input  logic                clk64,
   input  logic                rx_dsp_reset,
   input  logic [adc_w-1:0]    rx_a_a,
   input  logic [adc_w-1:0]    rx_b_a,
   input  logic [adc_w-1:0]    rx_a_b,
   input  logic [adc_w-1:0]    rx_b_b,
   input  logic [3:0]          io_bits,
   input  logic [src_w-1:0]    vid_source,
   input  logic [src_w-1:0]    trg_source,
   input  logic [src_w-1:0]    arp_source,
   input  logic [src_w-1:0]    acp_source,
   input  logic [mode_w-1:0]   radar_mode,
   input  logic                vid_negate,
   input  logic                decim_strobe,  // take a sample now
   input  logic [1:0]          phase,         // interleave slot
   output logic [adc_w-1:0]    vid_signal,
   output logic [adc_w-1:0]    trg_signal,
   output logic [adc_w-1:0]    arp_signal,
   output logic [adc_w-1:0]    acp_signal,
   output logic                sample_valid,
   output logic [sample_w-1:0] sample_data
);

   logic [adc_w-1:0] mode_word;  // sample picked by the mode

   // one source selector, shared by all four signals
   function automatic logic [adc_w-1:0] route(input logic [src_w-1:0] src);
      case (src)
         src_rx_a_a: return rx_a_a;
         src_rx_b_a: return rx_b_a;
         src_rx_a_b: return rx_a_b;
         src_rx_b_b: return rx_b_b;
         src_io_a0:  return {io_bits[0], {(adc_w-1){1'b0}}};  // pin into msb
         src_io_a1:  return {io_bits[1], {(adc_w-1){1'b0}}};
         src_io_b0:  return {io_bits[2], {(adc_w-1){1'b0}}};
         src_io_b1:  return {io_bits[3], {(adc_w-1){1'b0}}};
         default:    return '0;
      endcase
   endfunction

   always_comb
   begin
      vid_signal = route(vid_source);
      trg_signal = route(trg_source);
      arp_signal = route(arp_source);
      acp_signal = route(acp_source);
   end

   always_comb
   begin
      case (radar_mode)
         mode_video:      mode_word = vid_negate ? adc_full - vid_signal : vid_signal;
         mode_raw_vid:    mode_word = vid_signal;
         mode_raw_trg:    mode_word = trg_signal;
         mode_raw_arp:    mode_word = arp_signal;
         mode_raw_acp:    mode_word = acp_signal;
         mode_interleave:
            case (phase)  // vid, trg, arp, acp in turn
               2'd0:    mode_word = vid_signal;
               2'd1:    mode_word = trg_signal;
               2'd2:    mode_word = arp_signal;
               default: mode_word = acp_signal;
            endcase
         default:         mode_word = '0;
      endcase
   end

   always_ff @(posedge clk64)
   begin
      if (rx_dsp_reset)
         sample_valid <= 1'b0;
      else
         sample_valid <= decim_strobe;  // valid the cycle after the strobe
   end

   always_ff @(posedge clk64)
   begin
      if (decim_strobe)
         sample_data <= {{(sample_w-adc_w){1'b0}}, mode_word};
   end

endmodule

//--- sweep_tracker.sv
// acp, arp and trigger bookkeeping between pulses
// and acp-based sweep counting
`timescale 1ns/100ps

module sweep_tracker import radar_pkg::*;
(
   input  logic             clk64,
   input  logic             rx_dsp_reset,
   input  logic             trig_strobe,
   input  logic             arp_strobe,
   input  logic             acp_strobe,
   input  logic             sweep_start,                  // capture start from the sequencer
   input  logic [cnt_w-1:0] n_acps,
   input  logic [cnt_w-1:0] acp_interval,
   input  logic [cnt_w-1:0] acp_age,
   input  logic             use_acp_for_sweeps,
   input  logic [15:0]      n_acps_per_sweep,
   output logic [cnt_w-1:0] acp_count_last_arp,           // acp count at the last arp
   output logic [cnt_w-1:0] acp_age_last_arp,             // acp age at the last arp
   output logic [cnt_w-1:0] last_acp_interval_with_trig,
   output logic [cnt_w-1:0] last_acp_interval_with_arp,
   output logic [15:0]      acps_this_sweep,
   output logic [cnt_w-1:0] ticks_this_sweep
);

   logic        trig_q;         // trigger strobe, one cycle back
   logic        trig_seen;      // triggered capture since the last acp
   logic        arp_seen;       // arp since the last acp
   logic        got_first_acp;  // first sweep has begun
   logic [15:0] acps_next;
   logic        sweep_wrap;     // sweep length reached
   logic        sweep_restart;  // this acp begins a new sweep

   assign acps_next     = acps_this_sweep + 16'd1;
   assign sweep_wrap    = (acps_next == n_acps_per_sweep);
   assign sweep_restart = use_acp_for_sweeps & acp_strobe & (~got_first_acp | sweep_wrap);

   always_ff @(posedge clk64)
   begin
      if (rx_dsp_reset)
      begin
         trig_q                      <= 1'b0;
         trig_seen                   <= 1'b0;
         arp_seen                    <= 1'b0;
         got_first_acp               <= 1'b0;
         acp_count_last_arp          <= '0;
         acp_age_last_arp            <= '0;
         last_acp_interval_with_trig <= '0;
         last_acp_interval_with_arp  <= '0;
         acps_this_sweep             <= '0;
         ticks_this_sweep            <= '0;
      end
      else
      begin
         trig_q <= trig_strobe;
         if (arp_strobe)
         begin
            acp_count_last_arp <= n_acps;
            acp_age_last_arp   <= acp_age;
         end
         // interval is already the one just ended when the acp strobe is up
         if (acp_strobe & trig_seen)
            last_acp_interval_with_trig <= acp_interval;
         if (acp_strobe & arp_seen)
            last_acp_interval_with_arp <= acp_interval;
         // a new event on the acp cycle counts for the next interval
         trig_seen <= (sweep_start & trig_q) | (trig_seen & ~acp_strobe);
         arp_seen  <= arp_strobe | (arp_seen & ~acp_strobe);
         if (use_acp_for_sweeps)
         begin
            if (acp_strobe)
            begin
               got_first_acp   <= 1'b1;
               acps_this_sweep <= (~got_first_acp | sweep_wrap) ? 16'd0 : acps_next;
            end
            ticks_this_sweep <= sweep_restart ? '0 : ticks_this_sweep + 1'b1;
         end
      end
   end

endmodule

//--- tb_radar_digitizer.sv
// directed testbench for the radar digitizer
// settling, hysteresis, pulsed capture, routing modes and sweep bookkeeping
`timescale 1ns/100ps

module tb_radar_digitizer;
   import radar_pkg::*;

   localparam int clk_period = 100;
   localparam int idle_limit = 200;                          // cycles allowed for a capture to end
   localparam int test_cycles = 30 + 20 + 100 + 300 + 80;    // per-test budgets summed
   localparam int wd_cycles = 2 * test_cycles + 6 * idle_limit;

   logic                clk64 = 1'b0;
   logic                rx_dsp_reset;
   logic                eventually_enable_rx;
   logic [adc_w-1:0]    rx_a_a, rx_b_a, rx_a_b, rx_b_b;
   logic [3:0]          io_bits;
   logic [src_w-1:0]    vid_source, trg_source, arp_source, acp_source;
   logic [mode_w-1:0]   radar_mode;
   logic                new_mode, vid_negate;
   logic [15:0]         decim_rate;
   logic [cnt_w-1:0]    n_samples;
   logic [adc_w-1:0]    trig_thresh_excite, trig_thresh_relax;
   logic [adc_w-1:0]    arp_thresh_excite, arp_thresh_relax;
   logic [adc_w-1:0]    acp_thresh_excite, acp_thresh_relax;
   logic                use_acp_for_sweeps;
   logic [15:0]         n_acps_per_sweep;
   logic                sample_valid, enable_rx, pipeline_active;
   logic [sample_w-1:0] sample_data;
   logic [cnt_w-1:0]    n_trigs, n_arps, n_acps, trig_interval;
   logic [cnt_w-1:0]    acp_count_last_arp, acp_age_last_arp;
   logic [cnt_w-1:0]    last_acp_interval_with_trig, last_acp_interval_with_arp;
   logic [15:0]         acps_this_sweep;
   logic [cnt_w-1:0]    ticks_this_sweep;

   integer seed = 32'h52e2_2af4;
   integer cyc  = 0;  // edges seen by step

   radar_digitizer #(.ENABLE_DELAY(20), .DECIM_W(16)) UUT (.*);

   always #(clk_period/2) clk64 = ~clk64;

   // watchdog
   initial
   begin
      #(wd_cycles * clk_period);
      $display("watchdog expired, the tests did not finish in time");
      $display("SIMULATION FAILED");
      $fatal(1, "timeout");
   end

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("SIMULATION FAILED");
      $fatal(1, "check failed");
   endtask

   task automatic check_sample(input string name, input logic [sample_w-1:0] got,
                               input logic [sample_w-1:0] exp);
      if (got !== exp)
         abort_run($sformatf("[FAIL] t=%0t %s got %0d expected %0d", $time, name, got, exp));
   endtask

   task automatic check_count(input string name, input logic [cnt_w-1:0] got,
                              input logic [cnt_w-1:0] exp);
      if (got !== exp)
         abort_run($sformatf("[FAIL] t=%0t %s got %0d expected %0d", $time, name, got, exp));
   endtask

   // one clock, inputs change a ns after the edge
   task automatic step;
      @(posedge clk64);
      #1;
      cyc = cyc + 1;
   endtask

   // a start still in flight shows up within two cycles
   task automatic wait_idle;
      integer n;
      n = 0;
      repeat (2) step;
      while (pipeline_active)
      begin
         step;
         n = n + 1;
         if (n > idle_limit)
            abort_run("capture never ended, pipeline_active stuck high");
      end
      repeat (2) step;
   endtask

   // next sample registered after the current edge
   task automatic take_sample(output logic [sample_w-1:0] data);
      integer n;
      n = 0;
      do
      begin
         step;
         n = n + 1;
         if (n > idle_limit)
            abort_run("no sample_valid arrived in time");
      end
      while (!sample_valid);
      data = sample_data;
   endtask

   task automatic settling_delay;
      trg_source = src_rx_a_a;
      rx_a_a = 12'd3000;  // trigger held high while settling
      eventually_enable_rx = 1'b1;
      repeat (20)
      begin
         step;
         check_count("enable_rx", cnt_w'(enable_rx), 0);
         check_count("n_trigs", n_trigs, 0);
      end
      step;
      check_count("enable_rx", cnt_w'(enable_rx), 1);
      check_count("n_trigs", n_trigs, 0);
      step;
      check_count("n_trigs", n_trigs, 1);  // detector live right after enable
      rx_a_a = 12'd0;
      wait_idle;
   endtask

   task automatic trigger_hysteresis;
      logic [cnt_w-1:0] base;
      integer first;
      base = n_trigs;
      rx_a_a = 12'd3000;
      step;
      first = cyc;
      check_count("n_trigs", n_trigs, base + 1);
      rx_a_a = 12'd1000;  // hover between relax and excite
      repeat (3) step;
      rx_a_a = 12'd3000;
      repeat (2) step;
      check_count("n_trigs", n_trigs, base + 1);
      rx_a_a = 12'd1000;
      step;
      rx_a_a = 12'd100;   // re-arm
      step;
      rx_a_a = 12'd1000;
      step;
      rx_a_a = 12'd3000;
      step;
      check_count("n_trigs", n_trigs, base + 2);
      check_count("trig_interval", trig_interval, cyc - first);
      rx_a_a = 12'd0;
      wait_idle;
   endtask

   task automatic pulsed_capture;
      logic [adc_w-1:0] vid;
      integer got_n;
      vid = adc_w'($random(seed));
      decim_rate = 16'd3;
      n_samples = 5;
      vid_negate = 1'b1;
      vid_source = src_rx_b_a;
      rx_b_a = vid;
      step;
      rx_a_a = 12'd3000;  // one trigger pulse
      step;
      rx_a_a = 12'd0;
      step;
      check_count("pipeline_active", cnt_w'(pipeline_active), 1);  // opens after the strobe
      got_n = 0;
      repeat (39)
      begin
         step;
         if (sample_valid)
         begin
            got_n = got_n + 1;
            check_sample("sample_data", sample_data, sample_w'(12'd4095 - vid));
         end
      end
      check_count("samples per trigger", got_n, 5);
      repeat (20)
      begin
         step;
         check_count("pipeline_active", cnt_w'(pipeline_active), 0);
         check_count("sample_valid", cnt_w'(sample_valid), 0);  // quiet until next trigger
      end
      vid_negate = 1'b0;
   endtask

   task automatic routing_and_modes;
      logic [sample_w-1:0] d;
      logic [adc_w-1:0]    x;
      logic [adc_w-1:0]    vals [4];
      logic [cnt_w-1:0]    base;
      x = adc_w'($random(seed));
      wait_idle;
      trg_source = src_rx_a_b;
      rx_a_b = x;
      radar_mode = mode_raw_trg;
      new_mode = 1'b1;  // latch non-stop
      decim_rate = 16'd2;
      n_samples = 3;
      step;
      new_mode = 1'b0;
      repeat (6)
      begin
         take_sample(d);
         check_sample("raw trigger", d, sample_w'(x));
      end
      arp_source = src_io_b1;
      io_bits = 4'b1000;
      radar_mode = mode_raw_arp;
      repeat (3)
      begin
         take_sample(d);
         check_sample("raw arp pin high", d, 16'd2048);
      end
      io_bits = 4'b0000;
      repeat (3)
      begin
         take_sample(d);
         check_sample("raw arp pin low", d, 16'd0);
      end
      radar_mode = mode_video;  // back to pulsed before the interleave run
      new_mode = 1'b1;
      step;
      new_mode = 1'b0;
      wait_idle;
      vals[0] = 12'd100;
      vals[1] = 12'd200;
      vals[2] = 12'd300;
      vals[3] = 12'd400;
      vid_source = src_rx_b_a;
      trg_source = src_rx_a_b;
      arp_source = src_rx_b_b;
      acp_source = src_rx_a_a;
      rx_b_a = vals[0];
      rx_a_b = vals[1];
      rx_b_b = vals[2];
      rx_a_a = vals[3];
      repeat (3) step;
      base = n_trigs;
      radar_mode = mode_interleave;
      n_samples = 6;  // not a multiple of 4, shows the phase restart
      new_mode = 1'b1;
      step;
      new_mode = 1'b0;
      for (int k = 0; k < 12; k++)
      begin
         take_sample(d);
         check_sample("interleave", d, sample_w'(vals[(k % 6) % 4]));
      end
      check_count("n_trigs", n_trigs, base);  // restarts need no trigger
      radar_mode = mode_video;
      new_mode = 1'b1;
      step;
      new_mode = 1'b0;
      wait_idle;
   endtask

   task automatic sweep_bookkeeping;
      integer acp_cyc [5];
      integer gap;
      integer sweep_cyc;
      logic [cnt_w-1:0] arp_base;
      trg_source = src_io_a0;
      acp_source = src_rx_a_a;
      arp_source = src_rx_b_b;
      rx_a_a = 12'd0;
      rx_b_b = 12'd0;
      io_bits = 4'b0000;
      use_acp_for_sweeps = 1'b1;
      n_acps_per_sweep = 16'd4;
      sweep_cyc = 0;
      repeat (3) step;
      arp_base = n_arps;
      for (int i = 0; i < 5; i++)
      begin
         gap = 6 + ($random(seed) & 3);
         rx_a_a = 12'd3000;
         step;
         acp_cyc[i] = cyc;
         rx_a_a = 12'd0;
         step;  // tracker sees the strobe here
         if (i % 4 == 0)
            sweep_cyc = cyc;  // this acp opens a sweep
         check_count("n_acps", n_acps, i + 1);
         check_count("acps_this_sweep", cnt_w'(acps_this_sweep), i % 4);
         check_count("ticks_this_sweep", ticks_this_sweep, cyc - sweep_cyc);
         if (i == 2)
            check_count("last_acp_interval_with_trig", last_acp_interval_with_trig,
                        acp_cyc[2] - acp_cyc[1]);
         if (i == 4)
            check_count("last_acp_interval_with_arp", last_acp_interval_with_arp,
                        acp_cyc[4] - acp_cyc[3]);
         if (i == 1)
         begin
            io_bits = 4'b0001;  // trigger pin, pulsed capture inside this acp interval
            step;
            io_bits = 4'b0000;
            step;
            repeat (gap - 4) step;
         end
         else if (i == 3)
         begin
            rx_b_b = 12'd3000;  // heading pulse inside this acp interval
            step;
            rx_b_b = 12'd0;
            step;
            check_count("n_arps", n_arps, arp_base + 1);
            check_count("acp_count_last_arp", acp_count_last_arp, 4);
            // acp age during the arp strobe cycle
            check_count("acp_age_last_arp", acp_age_last_arp, cyc - acp_cyc[3] - 1);
            repeat (gap - 4) step;
         end
         else
            repeat (gap - 2) step;
      end
   endtask

   initial
   begin
      rx_dsp_reset = 1'b1;
      eventually_enable_rx = 1'b0;
      rx_a_a = '0;
      rx_b_a = '0;
      rx_a_b = '0;
      rx_b_b = '0;
      io_bits = '0;
      vid_source = src_rx_b_a;
      trg_source = 8'hff;  // unused code, zero signal
      arp_source = 8'hff;
      acp_source = 8'hff;
      radar_mode = mode_video;
      new_mode = 1'b0;
      vid_negate = 1'b0;
      decim_rate = 16'd1;
      n_samples = 2;
      trig_thresh_excite = 12'd2000;
      trig_thresh_relax = 12'd500;
      arp_thresh_excite = 12'd2000;
      arp_thresh_relax = 12'd500;
      acp_thresh_excite = 12'd2000;
      acp_thresh_relax = 12'd500;
      use_acp_for_sweeps = 1'b0;
      n_acps_per_sweep = 16'd4;
      repeat (2) step;
      rx_dsp_reset = 1'b0;
      settling_delay;
      trigger_hysteresis;
      pulsed_capture;
      routing_and_modes;
      sweep_bookkeeping;
      $display("SIMULATION PASSED");
      $finish;
   end

endmodule
